// File: compile.f
+incdir+source
source/trigReadoutPkg.sv
source/columnAdapter.sv
source/columnAdapterChain.sv
source/trigWordFifo.sv
source/trigReadoutTop.sv
tests/trigReadoutTop_sva.sv
tests/trigReadoutTop_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module trigReadoutTop_tb -f compile.f -Mdir build -o simv

./build/simv | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/columnAdapter.sv
module columnAdapter
    import trigReadoutPkg::*;
(
    input  groupHits_t trigHits,
    input  logic       columnMaskBit,
    input  colAddr_t   columnAddrIn,
    output colAddr_t   columnAddrNextOut,
    input  halfHits_t  upHits,
    output halfHits_t  dnHits
);

    logic      columnHit;
    halfHits_t localHits;

    ////////////////////////////////////////////////////////////
    // address ripple
    ////////////////////////////////////////////////////////////

    // next column sits one address higher
    assign columnAddrNextOut = columnAddrIn + colAddr_t'(1);

    ////////////////////////////////////////////////////////////
    // hit reduction and merge
    ////////////////////////////////////////////////////////////

    // any group fires the column, unless masked off
    assign columnHit = (|trigHits) & columnMaskBit;

    // low address bits pick the slot inside the half
    always_comb
    begin
        localHits = '0;
        localHits[columnAddrIn[2:0]] = columnHit;
    end

    // add our hit on top of what came from upstream
    assign dnHits = upHits | localHits;

endmodule

// File: source/columnAdapterChain.sv
`include "etroc_defs.svh"

module columnAdapterChain
    import trigReadoutPkg::*;
(
    input  logic [`NUM_COLUMNS*`NUM_GROUPS-1:0] trigHitsColumn,
    input  trigHits_t                           columnMask,
    output trigHits_t                           trigHits
);

    // one extra entry for the address leaving the last column
    colAddr_t  columnAddrChain [`NUM_COLUMNS+1];
    halfHits_t rightHitsChain [`HALF_COLUMNS+1];
    halfHits_t leftHitsChain [`HALF_COLUMNS+1];

    // chain ends
    assign columnAddrChain[0] = '0;
    assign rightHitsChain[0] = '0;
    assign leftHitsChain[`HALF_COLUMNS] = '0;

    ////////////////////////////////////////////////////////////
    // right half, column 0 up to 7
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `HALF_COLUMNS; i++)
    begin : gRight
        columnAdapter columnAdapterInst (
            .trigHits          (trigHitsColumn[i*`NUM_GROUPS +: `NUM_GROUPS]),
            .columnMaskBit     (columnMask[i]),
            .columnAddrIn      (columnAddrChain[i]),
            .columnAddrNextOut (columnAddrChain[i+1]),
            .upHits            (rightHitsChain[i]),
            .dnHits            (rightHitsChain[i+1])
        );
    end

    ////////////////////////////////////////////////////////////
    // left half, column 15 down to 8
    ////////////////////////////////////////////////////////////

    // address still ripples upward, hits flow the other way
    for (genvar i = `HALF_COLUMNS; i < `NUM_COLUMNS; i++)
    begin : gLeft
        columnAdapter columnAdapterInst (
            .trigHits          (trigHitsColumn[i*`NUM_GROUPS +: `NUM_GROUPS]),
            .columnMaskBit     (columnMask[i]),
            .columnAddrIn      (columnAddrChain[i]),
            .columnAddrNextOut (columnAddrChain[i+1]),
            .upHits            (leftHitsChain[i-`HALF_COLUMNS+1]),
            .dnHits            (leftHitsChain[i-`HALF_COLUMNS])
        );
    end

    // left result lands at column 8, right result at column 7
    assign trigHits = {leftHitsChain[0], rightHitsChain[`HALF_COLUMNS]};

endmodule

// File: source/etroc_defs.svh
`ifndef ETROC_DEFS_SVH
`define ETROC_DEFS_SVH

// matrix geometry
`define NUM_COLUMNS 16
`define NUM_GROUPS 4

// each half chain covers this many columns
`define HALF_COLUMNS 8

// trigger word queue depth, power of two
`define TRIG_FIFO_DEPTH 4

`endif

// File: source/trigReadoutPkg.sv
`include "etroc_defs.svh"

package trigReadoutPkg;

    // column address along the chain
    typedef logic [3:0] colAddr_t;

    // group-level trigger bits of one column
    typedef logic [`NUM_GROUPS-1:0] groupHits_t;

    // one bit per column within a half
    typedef logic [`HALF_COLUMNS-1:0] halfHits_t;

    // bit n set when column n hit
    typedef logic [`NUM_COLUMNS-1:0] trigHits_t;

    typedef logic [7:0] bcId_t;
    typedef logic [$bits(bcId_t)-1:0] ovfCount_t;

    // bcId on top, hit vector below
    typedef logic [$bits(bcId_t)+$bits(trigHits_t)-1:0] trigWord_t;

endpackage

// File: source/trigReadoutTop.sv
`include "etroc_defs.svh"

module trigReadoutTop
    import trigReadoutPkg::*;
(
    input  logic                                clk40,
    input  logic                                reset,
    input  logic [`NUM_COLUMNS*`NUM_GROUPS-1:0] trigHitsColumn,
    input  trigHits_t                           columnMask,
    input  logic                                hitStrobe,
    output logic                                outValid,
    input  logic                                outReady,
    output trigWord_t                           outWord,
    output ovfCount_t                           overflowCount
);

    trigHits_t trigHits;
    bcId_t     bcId;
    logic      pushValid;
    trigWord_t pushWord;

    ////////////////////////////////////////////////////////////
    // hit collection
    ////////////////////////////////////////////////////////////

    columnAdapterChain chainInst (
        .trigHitsColumn (trigHitsColumn),
        .columnMask     (columnMask),
        .trigHits       (trigHits)
    );

    ////////////////////////////////////////////////////////////
    // bunch crossing tag
    ////////////////////////////////////////////////////////////

    // free running, wraps at 256
    always_ff @(posedge clk40)
    begin
        if (reset)
            bcId <= '0;
        else
            bcId <= bcId + 1'b1;
    end

    // only non-empty crossings get queued
    assign pushValid = hitStrobe & (|trigHits);
    assign pushWord = {bcId, trigHits};

    trigWordFifo fifoInst (
        .clk40         (clk40),
        .reset         (reset),
        .pushValid     (pushValid),
        .pushWord      (pushWord),
        .outValid      (outValid),
        .outReady      (outReady),
        .outWord       (outWord),
        .overflowCount (overflowCount)
    );

endmodule

// File: source/trigWordFifo.sv
`include "etroc_defs.svh"

module trigWordFifo
    import trigReadoutPkg::*;
(
    input  logic       clk40,
    input  logic       reset,
    input  logic       pushValid,
    input  trigWord_t  pushWord,
    output logic       outValid,
    input  logic       outReady,
    output trigWord_t  outWord,
    output ovfCount_t  overflowCount
);

    localparam int Depth = `TRIG_FIFO_DEPTH;
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    trigWord_t             mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  full;
    logic                  pushFire;
    logic                  popFire;

    // wrap explicitly at the last entry
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        nextPtr = (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // status and handshake
    ////////////////////////////////////////////////////////////

    assign full = (count == CountWidth'(Depth));
    assign outValid = (count != '0);
    assign outWord = mem[rdPtr];
    assign popFire = outValid & outReady;

    // a pop frees the slot in the same cycle, so full plus pop still accepts
    assign pushFire = pushValid & (~full | popFire);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk40)
    begin
        if (pushFire)
        begin
            mem[wrPtr] <= pushWord;
        end
    end

    // pointers, occupancy, overflow
    always_ff @(posedge clk40)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            overflowCount <= '0;
        end
        else
        begin
            if (pushFire)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popFire)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushFire, popFire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped word, counter sticks at max
            if (pushValid && !pushFire && overflowCount != '1)
            begin
                overflowCount <= overflowCount + 1'b1;
            end
        end
    end

endmodule

// File: tests/trigReadoutTop_sva.sv
module trigReadoutTop_sva
    import trigReadoutPkg::*;
(
    input logic      clk40,
    input logic      reset,
    input logic      outValid,
    input logic      outReady,
    input trigWord_t outWord,
    input ovfCount_t overflowCount
);

    timeunit 1ns;
    timeprecision 100ps;

    // FIFO comes up empty
    resetEmpty: assert property (@(posedge clk40) reset |=> !outValid)
        else $error("outValid high in the cycle after reset");

    // stalled word must not change
    holdWord: assert property (@(posedge clk40) disable iff (reset)
        outValid && !outReady |=> $stable(outWord))
        else $error("outWord changed while stalled");

    ovfMonotonic: assert property (@(posedge clk40) disable iff (reset)
        !reset |=> overflowCount >= $past(overflowCount))
        else $error("overflowCount decreased");

endmodule

bind trigWordFifo trigReadoutTop_sva svaInst (
    .clk40         (clk40),
    .reset         (reset),
    .outValid      (outValid),
    .outReady      (outReady),
    .outWord       (outWord),
    .overflowCount (overflowCount)
);

// File: tests/trigReadoutTop_tb.sv
`include "etroc_defs.svh"

module trigReadoutTop_tb
    import trigReadoutPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FifoDepth = `TRIG_FIFO_DEPTH;
    localparam int NumColumns = `NUM_COLUMNS;
    localparam int NumGroups = `NUM_GROUPS;
    // about twice the summed length of all tests
    localparam int CycleLimit = 3000;
    localparam int DrainLimit = 40;

    logic                            clk40;
    logic                            reset;
    logic [NumColumns*NumGroups-1:0] trigHitsColumn;
    trigHits_t                       columnMask;
    logic                            hitStrobe;
    logic                            outValid;
    logic                            outReady;
    trigWord_t                       outWord;
    ovfCount_t                       overflowCount;

    // reference state
    bcId_t       bcModel;
    trigWord_t   wordQueue [$];
    int          ovfModel = 0;
    int          errorCount = 0;
    int          cycleCount = 0;
    logic [15:0] lfsrState;

    trigReadoutTop dut_i (
        .clk40          (clk40),
        .reset          (reset),
        .trigHitsColumn (trigHitsColumn),
        .columnMask     (columnMask),
        .hitStrobe      (hitStrobe),
        .outValid       (outValid),
        .outReady       (outReady),
        .outWord        (outWord),
        .overflowCount  (overflowCount)
    );

    initial clk40 = 1'b0;
    always #20 clk40 = ~clk40;

    // bunch crossing reads 0 in the first cycle after reset
    always @(posedge clk40)
    begin
        if (reset)
            bcModel <= '0;
        else
            bcModel <= bcModel + 8'd1;
    end

    always @(posedge clk40)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("timeout: tests still running after %0d cycles", CycleLimit);
            $display("errors: %0d", errorCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic randomBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit)
            lfsrState = lfsrState ^ 16'hB400;
        return outBit;
    endfunction

    function automatic logic [63:0] randomBits(input int width);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < width; i++)
            value[i] = randomBit();
        return value;
    endfunction

    // column n hits when unmasked and any group fired
    function automatic trigHits_t expectedHits(input logic [63:0] columns,
                                               input trigHits_t mask);
        trigHits_t hits;
        for (int n = 0; n < NumColumns; n++)
            hits[n] = mask[n] & (|columns[n*NumGroups +: NumGroups]);
        return hits;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // inputs change a little after the rising edge
    task automatic nextDriveSlot();
        @(posedge clk40);
        #2;
    endtask

    task automatic idleInputs();
        hitStrobe = 1'b0;
        trigHitsColumn = '0;
    endtask

    task automatic drainFifo();
        int waited;
        waited = 0;
        outReady = 1'b1;
        while ((wordQueue.size() != 0 || outValid) && waited < DrainLimit)
        begin
            nextDriveSlot();
            waited++;
        end
        assert (wordQueue.size() == 0 && !outValid)
        else
        begin
            errorCount++;
            $display("FIFO did not drain within %0d cycles", DrainLimit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk40)
    begin : scoreboard
        trigHits_t hits;
        logic      popNow;
        if (reset)
        begin
            wordQueue.delete();
            ovfModel = 0;
        end
        else
        begin
            checkValue("outValid", 32'(wordQueue.size() != 0), 32'(outValid));
            checkValue("overflowCount", 32'(ovfModel), 32'(overflowCount));
            popNow = (wordQueue.size() != 0) && outReady;
            if (popNow)
            begin
                checkValue("outWord", 32'(wordQueue[0]), 32'(outWord));
                void'(wordQueue.pop_front());
            end
            hits = expectedHits(trigHitsColumn, columnMask);
            // full without a pop drops the word
            if (hitStrobe && hits != '0)
            begin
                if (wordQueue.size() < FifoDepth || popNow)
                    wordQueue.push_back({bcModel, hits});
                else if (ovfModel < 255)
                    ovfModel++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic singleColumnTest();
        logic [1:0] group;
        bcId_t      pushedBc;
        int         waited;
        for (int col = 0; col < NumColumns; col++)
        begin
            group = 2'(randomBits(2));
            nextDriveSlot();
            columnMask = '1;
            outReady = 1'b1;
            trigHitsColumn = '0;
            trigHitsColumn[col*NumGroups + group] = 1'b1;
            hitStrobe = 1'b1;
            pushedBc = bcModel;
            nextDriveSlot();
            idleInputs();
            waited = 0;
            while (!outValid && waited < DrainLimit)
            begin
                nextDriveSlot();
                waited++;
            end
            assert (outValid)
            else
            begin
                errorCount++;
                $display("no word came out for column %0d", col);
            end
            checkValue("outWord", 32'({pushedBc, trigHits_t'(1) << col}), 32'(outWord));
            drainFifo();
        end
    endtask

    // sparse hits so the mask and empty columns both matter
    task automatic maskTest();
        for (int i = 0; i < 500; i++)
        begin
            nextDriveSlot();
            trigHitsColumn = randomBits(64) & randomBits(64) & randomBits(64);
            columnMask = trigHits_t'(randomBits(NumColumns));
            hitStrobe = 1'b1;
            outReady = 1'b1;
        end
        nextDriveSlot();
        idleInputs();
        drainFifo();
    endtask

    task automatic noPushTest();
        outReady = 1'b1;
        for (int i = 0; i < 12; i++)
        begin
            nextDriveSlot();
            checkValue("outValid", 32'(0), 32'(outValid));
            if (i % 3 == 0)
            begin
                columnMask = '1;
                trigHitsColumn = '0;
                hitStrobe = 1'b1;
            end
            else if (i % 3 == 1)
            begin
                columnMask = '1;
                trigHitsColumn = randomBits(64) | 64'd1;
                hitStrobe = 1'b0;
            end
            else
            begin
                columnMask = '0;
                trigHitsColumn = randomBits(64) | 64'd1;
                hitStrobe = 1'b1;
            end
        end
        nextDriveSlot();
        idleInputs();
        checkValue("outValid", 32'(0), 32'(outValid));
        nextDriveSlot();
        checkValue("outValid", 32'(0), 32'(outValid));
    endtask

    task automatic backPressureTest();
        trigWord_t firstWord;
        nextDriveSlot();
        outReady = 1'b0;
        columnMask = '1;
        // one more push than the FIFO holds
        for (int i = 0; i < FifoDepth + 1; i++)
        begin
            trigHitsColumn = '0;
            trigHitsColumn[(i*3 % NumColumns)*NumGroups + (i % NumGroups)] = 1'b1;
            hitStrobe = 1'b1;
            if (i == 0)
                firstWord = {bcModel, trigHits_t'(1)};
            nextDriveSlot();
        end
        idleInputs();
        checkValue("overflowCount", 32'(1), 32'(overflowCount));
        for (int i = 0; i < 3; i++)
        begin
            checkValue("outValid", 32'(1), 32'(outValid));
            checkValue("outWord", 32'(firstWord), 32'(outWord));
            nextDriveSlot();
        end
        drainFifo();
    endtask

    task automatic streamTest();
        for (int i = 0; i < 700; i++)
        begin
            nextDriveSlot();
            columnMask = '1;
            trigHitsColumn = randomBits(64) & randomBits(64);
            hitStrobe = 1'b1;
            // ready about three cycles in four
            outReady = randomBit() | randomBit();
        end
        nextDriveSlot();
        idleInputs();
        drainFifo();
    endtask

    initial
    begin
        lfsrState = 16'd49;
        reset = 1'b1;
        hitStrobe = 1'b0;
        trigHitsColumn = '0;
        columnMask = '0;
        outReady = 1'b0;
        repeat (4) @(posedge clk40);
        #2;
        reset = 1'b0;
        singleColumnTest();
        maskTest();
        noPushTest();
        backPressureTest();
        streamTest();
        nextDriveSlot();
        $display("errors: %0d", errorCount);
        if (errorCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
